// File: Bender.yml
package:
  name: operand_stage

sources:
  # Packages first, then the RTL bottom up
  - source/rv_arch_pkg.sv
  - source/fwd_pkg.sv
  - source/reg_file.sv
  - source/wb_arbiter.sv
  - source/bypass_mux.sv
  - source/operand_stage.sv

  - target: simulation
    files:
      - tests/tb_operand_stage.sv

// File: source/bypass_mux.sv
`timescale 1ns/1ps

module bypass_mux (
    input  logic [rv_arch_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [rv_arch_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic                              rs1_used,
    input  logic                              rs2_used,
    input  logic                              ex_wen,
    input  logic                              ex_is_load,
    input  logic [rv_arch_pkg::reg_addr_w-1:0] ex_rd,
    input  logic [rv_arch_pkg::xlen-1:0]       ex_result,
    input  logic                              mem_wen,
    input  logic [rv_arch_pkg::reg_addr_w-1:0] mem_rd,
    input  logic [rv_arch_pkg::xlen-1:0]       mem_result,
    input  logic                              wb_we,
    input  logic [rv_arch_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [rv_arch_pkg::xlen-1:0]       wb_data,
    input  logic [rv_arch_pkg::xlen-1:0]       rf_rs1_data,
    input  logic [rv_arch_pkg::xlen-1:0]       rf_rs2_data,
    output logic [rv_arch_pkg::reg_addr_w-1:0] rf_rs1_addr,
    output logic [rv_arch_pkg::reg_addr_w-1:0] rf_rs2_addr,
    output logic [rv_arch_pkg::xlen-1:0]       rs1_data,
    output logic [rv_arch_pkg::xlen-1:0]       rs2_data,
    output logic                              load_use_stall
);

    import rv_arch_pkg::*;
    import fwd_pkg::*;

    fwd_sel_e rs1_sel;
    fwd_sel_e rs2_sel;

    logic rs1_ex_hit;
    logic rs1_mem_hit;
    logic rs1_wb_hit;
    logic rs2_ex_hit;
    logic rs2_mem_hit;
    logic rs2_wb_hit;
    logic rs1_load_use;
    logic rs2_load_use;

    // A producer matches only when it writes and targets the same nonzero register
    function automatic logic src_hit(
        input logic                  wen,
        input logic [reg_addr_w-1:0] rd,
        input logic [reg_addr_w-1:0] addr
    );
        return wen && (rd == addr) && (addr != '0);
    endfunction

    // The register file sees the raw operand addresses
    assign rf_rs1_addr = rs1_addr;
    assign rf_rs2_addr = rs2_addr;

    assign rs1_ex_hit  = src_hit(ex_wen, ex_rd, rs1_addr);
    assign rs1_mem_hit = src_hit(mem_wen, mem_rd, rs1_addr);
    assign rs1_wb_hit  = src_hit(wb_we, wb_rd, rs1_addr);
    assign rs2_ex_hit  = src_hit(ex_wen, ex_rd, rs2_addr);
    assign rs2_mem_hit = src_hit(mem_wen, mem_rd, rs2_addr);
    assign rs2_wb_hit  = src_hit(wb_we, wb_rd, rs2_addr);

    // A load in execute has no data yet, so the consumer must wait
    assign rs1_load_use   = rs1_used && rs1_ex_hit && ex_is_load;
    assign rs2_load_use   = rs2_used && rs2_ex_hit && ex_is_load;
    assign load_use_stall = rs1_load_use || rs2_load_use;

    always_comb begin
        if (rs1_ex_hit && !ex_is_load) begin
            rs1_sel = fwd_ex;
        end else if (rs1_mem_hit) begin
            rs1_sel = fwd_mem; // Also taken when the ex match is a pending load
        end else if (rs1_wb_hit) begin
            rs1_sel = fwd_wb;
        end else begin
            rs1_sel = fwd_rf;
        end

        case (rs1_sel)
            fwd_ex:  rs1_data = ex_result;
            fwd_mem: rs1_data = mem_result;
            fwd_wb:  rs1_data = wb_data;
            default: rs1_data = rf_rs1_data;
        endcase
    end

    always_comb begin
        if (rs2_ex_hit && !ex_is_load) begin
            rs2_sel = fwd_ex;
        end else if (rs2_mem_hit) begin
            rs2_sel = fwd_mem;
        end else if (rs2_wb_hit) begin
            rs2_sel = fwd_wb;
        end else begin
            rs2_sel = fwd_rf;
        end

        case (rs2_sel)
            fwd_ex:  rs2_data = ex_result;
            fwd_mem: rs2_data = mem_result;
            fwd_wb:  rs2_data = wb_data;
            default: rs2_data = rf_rs2_data;
        endcase
    end

endmodule

// File: source/fwd_pkg.sv
package fwd_pkg;

    // Where an operand value comes from in the current cycle
    typedef enum logic [1:0] {
        fwd_rf  = 2'd0, // Register file read port
        fwd_ex  = 2'd1, // Execute stage result
        fwd_mem = 2'd2, // Memory stage result
        fwd_wb  = 2'd3  // Value on the write port this cycle
    } fwd_sel_e;

    // Which requester owns the register file write port this cycle
    typedef enum logic [1:0] {
        wb_none = 2'd0,
        wb_alu  = 2'd1,
        wb_load = 2'd2
    } wb_src_e;

endpackage

// File: source/operand_stage.sv
`timescale 1ns/1ps

module operand_stage (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [rv_arch_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [rv_arch_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic                              rs1_used,
    input  logic                              rs2_used,
    input  logic                              ex_wen,
    input  logic                              ex_is_load,
    input  logic [rv_arch_pkg::reg_addr_w-1:0] ex_rd,
    input  logic [rv_arch_pkg::xlen-1:0]       ex_result,
    input  logic                              mem_wen,
    input  logic [rv_arch_pkg::reg_addr_w-1:0] mem_rd,
    input  logic [rv_arch_pkg::xlen-1:0]       mem_result,
    input  logic                              alu_wb_req,
    input  logic [rv_arch_pkg::reg_addr_w-1:0] alu_wb_rd,
    input  logic [rv_arch_pkg::xlen-1:0]       alu_wb_data,
    input  logic                              load_wb_req,
    input  logic [rv_arch_pkg::reg_addr_w-1:0] load_wb_rd,
    input  logic [rv_arch_pkg::xlen-1:0]       load_wb_data,
    output logic [rv_arch_pkg::xlen-1:0]       rs1_data,
    output logic [rv_arch_pkg::xlen-1:0]       rs2_data,
    output logic                              load_use_stall,
    output logic                              alu_wb_stall,
    output logic                              load_wb_stall,
    output fwd_pkg::wb_src_e                  wb_grant
);

    import rv_arch_pkg::*;

    logic                  wb_we;      // Single write port shared by both writeback paths
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;
    logic [reg_addr_w-1:0] rf_rs1_addr;
    logic [reg_addr_w-1:0] rf_rs2_addr;
    logic [xlen-1:0]       rf_rs1_data;
    logic [xlen-1:0]       rf_rs2_data;

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rf_rs1_addr),
        .rs2_addr (rf_rs2_addr),
        .we       (wb_we),
        .waddr    (wb_rd),
        .wdata    (wb_data),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data)
    );

    wb_arbiter u_wb_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .alu_req    (alu_wb_req),
        .alu_rd     (alu_wb_rd),
        .alu_data   (alu_wb_data),
        .load_req   (load_wb_req),
        .load_rd    (load_wb_rd),
        .load_data  (load_wb_data),
        .wb_we      (wb_we),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .alu_stall  (alu_wb_stall),
        .load_stall (load_wb_stall),
        .grant      (wb_grant)
    );

    // The granted write is also forwarded in its own cycle
    bypass_mux u_bypass_mux (
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .rs1_used       (rs1_used),
        .rs2_used       (rs2_used),
        .ex_wen         (ex_wen),
        .ex_is_load     (ex_is_load),
        .ex_rd          (ex_rd),
        .ex_result      (ex_result),
        .mem_wen        (mem_wen),
        .mem_rd         (mem_rd),
        .mem_result     (mem_result),
        .wb_we          (wb_we),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .rf_rs1_data    (rf_rs1_data),
        .rf_rs2_data    (rf_rs2_data),
        .rf_rs1_addr    (rf_rs1_addr),
        .rf_rs2_addr    (rf_rs2_addr),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .load_use_stall (load_use_stall)
    );

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [rv_arch_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [rv_arch_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic                              we,
    input  logic [rv_arch_pkg::reg_addr_w-1:0] waddr,
    input  logic [rv_arch_pkg::xlen-1:0]       wdata,
    output logic [rv_arch_pkg::xlen-1:0]       rs1_data,
    output logic [rv_arch_pkg::xlen-1:0]       rs2_data
);

    import rv_arch_pkg::*;

    // x0 has no storage behind it
    logic [xlen-1:0] regs [1:num_regs-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata; // Writes to x0 are dropped here
        end
    end

    // Reads are asynchronous, a write shows up on the next cycle
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1_addr];
        end
    end

    always_comb begin
        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

// File: source/rv_arch_pkg.sv
package rv_arch_pkg;

    // Integer register width of the RV64 core
    localparam int xlen = 64;

    // x0 through x31
    localparam int num_regs = 32;

    // Address width that covers every integer register
    localparam int reg_addr_w = $clog2(num_regs);

endpackage

// File: source/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              alu_req,
    input  logic [rv_arch_pkg::reg_addr_w-1:0] alu_rd,
    input  logic [rv_arch_pkg::xlen-1:0]       alu_data,
    input  logic                              load_req,
    input  logic [rv_arch_pkg::reg_addr_w-1:0] load_rd,
    input  logic [rv_arch_pkg::xlen-1:0]       load_data,
    output logic                              wb_we,
    output logic [rv_arch_pkg::reg_addr_w-1:0] wb_rd,
    output logic [rv_arch_pkg::xlen-1:0]       wb_data,
    output logic                              alu_stall,
    output logic                              load_stall,
    output fwd_pkg::wb_src_e                  grant
);

    import rv_arch_pkg::*;
    import fwd_pkg::*;

    logic alu_lost_last; // Set when the ALU path lost the most recent conflict
    logic conflict;
    logic alu_win;
    logic load_win;

    assign conflict = alu_req && load_req;

    // On a conflict the previous loser goes first, so neither path starves
    assign alu_win  = alu_req && (!load_req || alu_lost_last);
    assign load_win = load_req && !alu_win;

    assign alu_stall  = alu_req && !alu_win;
    assign load_stall = load_req && !load_win;
    assign wb_we      = alu_win || load_win;

    always_comb begin
        grant   = wb_none;
        wb_rd   = '0;
        wb_data = {xlen{1'b0}};
        if (alu_win) begin
            grant   = wb_alu;
            wb_rd   = alu_rd;
            wb_data = alu_data;
        end else if (load_win) begin
            grant   = wb_load;
            wb_rd   = load_rd;
            wb_data = load_data;
        end
    end

    // Cleared by reset so the load path wins the first conflict
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_lost_last <= 1'b0;
        end else if (conflict) begin
            alu_lost_last <= load_win;
        end
    end

endmodule

// File: tests/operand_tests.txt
# name rnd rs1 rs2 use1 use2 ex_wen ex_load ex_rd ex_res mem_wen mem_rd mem_res
# alu_req alu_rd alu_data ld_req ld_rd ld_data, then expected rs1 rs2 luse alu_stall ld_stall grant
# All values hex. rnd bits 0 to 3 replace ex, mem, ALU and load data with random values
rst_rd_a f 01 1f 1 1 0 0 00 0 0 00 0 0 00 0 0 00 0 0 0 0 0 0 0
rst_rd_b f 0a 15 1 1 0 0 00 0 0 00 0 0 00 0 0 00 0 0 0 0 0 0 0
alu_wr_x5 b 05 00 1 1 0 0 00 0 0 00 0 1 05 1234abcd 0 00 0 1234abcd 0 0 0 0 1
alu_rd_x5 f 05 05 1 1 0 0 00 0 0 00 0 0 00 0 0 00 0 1234abcd 1234abcd 0 0 0 0
alu_wr_x0 b 00 00 1 1 0 0 00 0 0 00 0 1 00 ffff 0 00 0 0 0 0 0 0 1
x0_rd f 00 05 1 1 0 0 00 0 0 00 0 0 00 0 0 00 0 0 1234abcd 0 0 0 0
load_wr_x7 7 07 05 1 1 0 0 00 0 0 00 0 0 00 0 1 07 70000007 70000007 1234abcd 0 0 0 2
load_rd_x7 f 07 07 1 1 0 0 00 0 0 00 0 0 00 0 0 00 0 70000007 70000007 0 0 0 0
fwd1_ex 8 09 05 1 1 1 0 09 e1e1 1 09 a1a1 1 09 b1b1 0 00 0 e1e1 1234abcd 0 0 0 1
fwd1_mem 9 09 05 1 1 0 0 09 0 1 09 a2a2 1 09 b2b2 0 00 0 a2a2 1234abcd 0 0 0 1
fwd1_wb b 09 05 1 1 0 0 09 0 0 09 0 1 09 b3b3 0 00 0 b3b3 1234abcd 0 0 0 1
fwd1_rf f 09 05 1 1 0 0 09 0 0 09 0 0 09 0 0 00 0 b3b3 1234abcd 0 0 0 0
fwd2_ex 4 05 0a 1 1 1 0 0a e2e2 1 0a a4a4 0 00 0 1 0a c4c4 1234abcd e2e2 0 0 0 2
fwd2_mem 5 05 0a 1 1 0 0 0a 0 1 0a a5a5 0 00 0 1 0a c5c5 1234abcd a5a5 0 0 0 2
fwd2_wb 7 05 0a 1 1 0 0 0a 0 0 0a 0 0 00 0 1 0a c6c6 1234abcd c6c6 0 0 0 2
fwd2_rf f 05 0a 1 1 0 0 0a 0 0 0a 0 0 00 0 0 0a 0 1234abcd c6c6 0 0 0 0
fwd_split c 09 0a 1 1 1 0 09 e3e3 1 0a a7a7 0 00 0 0 00 0 e3e3 a7a7 0 0 0 0
fwd_miss c 09 0a 1 1 1 0 0b eeee 1 0c aaaa 0 00 0 0 00 0 b3b3 c6c6 0 0 0 0
fwd_x0 8 00 00 1 1 1 0 00 e0e0 1 00 a0a0 1 00 b0b0 0 00 0 0 0 0 0 0 1
lu_rs1_mem d 09 05 1 1 1 1 09 0 1 09 a8a8 0 00 0 0 00 0 a8a8 1234abcd 1 0 0 0
lu_rs2_wb b 05 0a 1 1 1 1 0a 0 0 00 0 1 0a b9b9 0 00 0 1234abcd b9b9 1 0 0 1
lu_rs1_rf f 09 05 1 1 1 1 09 0 0 00 0 0 00 0 0 00 0 b3b3 1234abcd 1 0 0 0
lu_unused f 09 0a 0 0 1 1 09 0 0 00 0 0 00 0 0 00 0 b3b3 b9b9 0 0 0 0
lu_x0 f 00 09 1 1 1 1 00 0 0 00 0 0 00 0 0 00 0 0 b3b3 0 0 0 0
lu_rs2_unused f 05 0a 1 0 1 1 0a 0 0 00 0 0 00 0 0 00 0 1234abcd b9b9 0 0 0 0
lu_no_wen f 09 09 1 1 0 1 09 0 0 00 0 0 00 0 0 00 0 b3b3 b3b3 0 0 0 0
wbc_first 3 0b 0c 1 1 0 0 00 0 0 00 0 1 0b 1b1b 1 0c 2c2c 0 2c2c 0 1 0 2
wbc_alu_hold b 0b 0c 1 1 0 0 00 0 0 00 0 1 0b 1b1b 0 00 0 1b1b 2c2c 0 0 0 1
wbc_second 3 0d 0e 1 1 0 0 00 0 0 00 0 1 0d 3d3d 1 0e 4e4e 3d3d 0 0 0 1 1
wbc_load_hold 7 0d 0e 1 1 0 0 00 0 0 00 0 0 00 0 1 0e 4e4e 3d3d 4e4e 0 0 0 2
wbc_third 3 0f 10 1 1 0 0 00 0 0 00 0 1 0f 5f5f 1 10 6060 0 6060 0 1 0 2
wbc_alu_hold2 b 0f 10 1 1 0 0 00 0 0 00 0 1 0f 5f5f 0 00 0 5f5f 6060 0 0 0 1
wbc_rd_a f 0b 0c 1 1 0 0 00 0 0 00 0 0 00 0 0 00 0 1b1b 2c2c 0 0 0 0
wbc_rd_b f 0d 0e 1 1 0 0 00 0 0 00 0 0 00 0 0 00 0 3d3d 4e4e 0 0 0 0
wbc_rd_c f 0f 10 1 1 0 0 00 0 0 00 0 0 00 0 0 00 0 5f5f 6060 0 0 0 0
same_wr b 11 11 1 1 0 0 00 0 0 00 0 1 11 f00dcafe1234 0 00 0 f00dcafe1234 f00dcafe1234 0 0 0 1
same_rd f 11 11 1 1 0 0 00 0 0 00 0 0 00 0 0 00 0 f00dcafe1234 f00dcafe1234 0 0 0 0
same_wr_wide 7 0c 0b 1 1 0 0 00 0 0 00 0 0 00 0 1 0c 8000000000000001 8000000000000001 1b1b 0 0 0 2
same_rd_wide f 0c 0c 1 1 0 0 00 0 0 00 0 0 00 0 0 00 0 8000000000000001 8000000000000001 0 0 0 0
wb_over_rf 7 09 0a 1 1 0 0 00 0 0 00 0 0 00 0 1 09 d1d1 d1d1 b9b9 0 0 0 2
rd_x9 f 09 0a 1 1 0 0 00 0 0 00 0 0 00 0 0 00 0 d1d1 b9b9 0 0 0 0
idle f 00 00 0 0 0 0 00 0 0 00 0 0 00 0 0 00 0 0 0 0 0 0 0

// File: tests/tb_operand_stage.sv
`timescale 1ns/1ps

module tb_operand_stage;

    import rv_arch_pkg::*;
    import fwd_pkg::*;

    localparam int reset_cycles = 16;

    logic                  clk;
    logic                  rst_n;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic                  rs1_used;
    logic                  rs2_used;
    logic                  ex_wen;
    logic                  ex_is_load;
    logic [reg_addr_w-1:0] ex_rd;
    logic [xlen-1:0]       ex_result;
    logic                  mem_wen;
    logic [reg_addr_w-1:0] mem_rd;
    logic [xlen-1:0]       mem_result;
    logic                  alu_wb_req;
    logic [reg_addr_w-1:0] alu_wb_rd;
    logic [xlen-1:0]       alu_wb_data;
    logic                  load_wb_req;
    logic [reg_addr_w-1:0] load_wb_rd;
    logic [xlen-1:0]       load_wb_data;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic                  load_use_stall;
    logic                  alu_wb_stall;
    logic                  load_wb_stall;
    wb_src_e               wb_grant;

    string                 test_name;
    logic [3:0]            random_mask;    // Bits 0 to 3 pick ex, mem, ALU and load data
    logic [xlen-1:0]       exp_rs1_data;
    logic [xlen-1:0]       exp_rs2_data;
    logic                  exp_load_use;
    logic                  exp_alu_stall;
    logic                  exp_load_stall;
    logic [1:0]            exp_grant;
    string                 vectors [$];
    int                    cycle_count = 0;
    int                    cycle_limit = 2 * reset_cycles;

    operand_stage u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .rs1_used       (rs1_used),
        .rs2_used       (rs2_used),
        .ex_wen         (ex_wen),
        .ex_is_load     (ex_is_load),
        .ex_rd          (ex_rd),
        .ex_result      (ex_result),
        .mem_wen        (mem_wen),
        .mem_rd         (mem_rd),
        .mem_result     (mem_result),
        .alu_wb_req     (alu_wb_req),
        .alu_wb_rd      (alu_wb_rd),
        .alu_wb_data    (alu_wb_data),
        .load_wb_req    (load_wb_req),
        .load_wb_rd     (load_wb_rd),
        .load_wb_data   (load_wb_data),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .load_use_stall (load_use_stall),
        .alu_wb_stall   (alu_wb_stall),
        .load_wb_stall  (load_wb_stall),
        .wb_grant       (wb_grant)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("simulation did not finish within the cycle limit");
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped after the first error");
    endtask

    task automatic check_value(input string name, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic read_vectors();
        int    fd;
        int    count;
        string line;
        fd = $fopen("tests/operand_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file tests/operand_tests.txt");
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            line = "";
            count = $fgets(line, fd);
            if (count > 2 && line.getc(0) != "#") begin
                vectors.push_back(line); // Lines starting with # describe the columns
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_vector(input string line);
        int fields;
        fields = $sscanf(line,
            "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            test_name, random_mask, rs1_addr, rs2_addr, rs1_used, rs2_used,
            ex_wen, ex_is_load, ex_rd, ex_result, mem_wen, mem_rd, mem_result,
            alu_wb_req, alu_wb_rd, alu_wb_data, load_wb_req, load_wb_rd, load_wb_data,
            exp_rs1_data, exp_rs2_data, exp_load_use, exp_alu_stall, exp_load_stall,
            exp_grant);
        if (fields != 25) begin
            $display("a vector line holds %0d fields where 25 are needed", fields);
            stop_with_failure();
        end
        // The expected outputs of these lines do not depend on the masked fields
        if (random_mask[0]) ex_result = {$urandom, $urandom};
        if (random_mask[1]) mem_result = {$urandom, $urandom};
        if (random_mask[2]) alu_wb_data = {$urandom, $urandom};
        if (random_mask[3]) load_wb_data = {$urandom, $urandom};
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        rs1_addr     = '0;
        rs2_addr     = '0;
        rs1_used     = 1'b0;
        rs2_used     = 1'b0;
        ex_wen       = 1'b0;
        ex_is_load   = 1'b0;
        ex_rd        = '0;
        ex_result    = '0;
        mem_wen      = 1'b0;
        mem_rd       = '0;
        mem_result   = '0;
        alu_wb_req   = 1'b0;
        alu_wb_rd    = '0;
        alu_wb_data  = '0;
        load_wb_req  = 1'b0;
        load_wb_rd   = '0;
        load_wb_data = '0;
        void'($urandom(32'h60eb_d63d));
        read_vectors();
        cycle_limit = 2 * (vectors.size() + reset_cycles);
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (vectors[i]) begin
            @(negedge clk);
            apply_vector(vectors[i]);
            #40; // Just ahead of the next rising edge
            check_value({test_name, ".rs1_data"}, exp_rs1_data, rs1_data);
            check_value({test_name, ".rs2_data"}, exp_rs2_data, rs2_data);
            check_value({test_name, ".load_use_stall"}, exp_load_use, load_use_stall);
            check_value({test_name, ".alu_wb_stall"}, exp_alu_stall, alu_wb_stall);
            check_value({test_name, ".load_wb_stall"}, exp_load_stall, load_wb_stall);
            check_value({test_name, ".wb_grant"}, exp_grant, wb_grant);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: verilog.f
source/rv_arch_pkg.sv
source/fwd_pkg.sv
source/reg_file.sv
source/wb_arbiter.sv
source/bypass_mux.sv
source/operand_stage.sv
tests/tb_operand_stage.sv
